//--- tb.f
+incdir+verilog
verilog/matmul_pkg.sv
verilog/operand_feeder.sv
verilog/matmul_sequencer.sv
verilog/systolic_array.sv
verilog/result_bank.sv
verilog/matmul_top.sv
verif/matmul_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the matmul testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module matmul_tb -o matmul_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/matmul_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

//--- verif/matmul_tb.sv
`timescale 1ns/100ps
`include "matmul_macros.svh"

module matmul_tb;
  import matmul_pkg::*;

  // five tests of about 60 cycles each, after the reset window
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 5 * 60 + RESET_CYCLES;

  // done is expected this many edges after start is first sampled
  localparam int DONE_LATENCY = 20;

  logic  clk;
  logic  reset;
  logic  load;
  logic  load_a;
  logic  load_b;
  logic  start;
  addr_t load_addr;
  addr_t read_addr;
  word_t load_data;
  logic  done;
  word_t read_data;

  // operands and expected saturated product
  elem_t ma [`ARRAY_N][`ARRAY_N];
  elem_t mb [`ARRAY_N][`ARRAY_N];
  elem_t exp_c [`ARRAY_N][`ARRAY_N];

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;
  int errs_before;

  matmul_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .load_a    (load_a),
    .load_b    (load_b),
    .start     (start),
    .load_addr (load_addr),
    .read_addr (read_addr),
    .load_data (load_data),
    .done      (done),
    .read_data (read_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // hard stop in case done never comes
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////
  // protocol assertions

  // done holds as long as start does
  done_holds: assert property (@(posedge clk) disable iff (reset) (done && start) |=> done)
    else begin
      errors = errors + 1;
      $display("done dropped at %0t while start was still high", $time);
    end

  // done low one cycle after start falls
  done_clears: assert property (@(posedge clk) disable iff (reset) $fell(start) |=> !done)
    else begin
      errors = errors + 1;
      $display("done still high at %0t one cycle after start fell", $time);
    end

  //////////////////////////////
  // helpers

  // inputs change just after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    checks = checks + 1;
    assert (actual === expected) else begin
      errors = errors + 1;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // A memory word k is column k of A
  function automatic word_t a_column(int k);
    word_t w;
    for (int i = 0; i < `ARRAY_N; i++) begin
      w[i*`ELEM_W +: `ELEM_W] = ma[i][k];
    end
    return w;
  endfunction

  // B memory word k is row k of B
  function automatic word_t b_row(int k);
    word_t w;
    for (int j = 0; j < `ARRAY_N; j++) begin
      w[j*`ELEM_W +: `ELEM_W] = mb[k][j];
    end
    return w;
  endfunction

  // lane r of word d is C[r][d-r], zero off the matrix
  function automatic word_t diag_word(int d);
    word_t w;
    int    c;
    w = '0;
    for (int r = 0; r < `ARRAY_N; r++) begin
      c = d - r;
      if (c >= 0 && c < `ARRAY_N) begin
        w[r*`ELEM_W +: `ELEM_W] = exp_c[r][c];
      end
    end
    return w;
  endfunction

  // reference product, clamped to 16 bits
  task automatic compute_product();
    logic [63:0] sum;
    for (int r = 0; r < `ARRAY_N; r++) begin
      for (int c = 0; c < `ARRAY_N; c++) begin
        sum = '0;
        for (int k = 0; k < `ARRAY_N; k++) begin
          sum = sum + 64'(ma[r][k]) * 64'(mb[k][c]);
        end
        exp_c[r][c] = (sum > 64'hffff) ? elem_t'(16'hffff) : elem_t'(sum);
      end
    end
  endtask

  task automatic fill_random(int a_limit, int b_limit);
    for (int i = 0; i < `ARRAY_N; i++) begin
      for (int j = 0; j < `ARRAY_N; j++) begin
        ma[i][j] = elem_t'($urandom_range(a_limit - 1));
        mb[i][j] = elem_t'($urandom_range(b_limit - 1));
      end
    end
  endtask

  task automatic load_operands();
    for (int k = 0; k < `ARRAY_N; k++) begin
      load      = 1'b1;
      load_a    = 1'b1;
      load_b    = 1'b0;
      load_addr = addr_t'(k);
      load_data = a_column(k);
      step();
      load_a    = 1'b0;
      load_b    = 1'b1;
      load_data = b_row(k);
      step();
    end
    load   = 1'b0;
    load_b = 1'b0;
  endtask

  // raise start, time done, hold a little, then drop start
  task automatic run_once();
    int steps;
    steps = 0;
    start = 1'b1;
    while (!done && steps < 2 * DONE_LATENCY) begin
      step();
      steps++;
    end
    if (!done) begin
      errors = errors + 1;
      $display("done never rose within %0d cycles of start", steps);
    end else begin
      // last step is the edge that raised done
      check_value("done latency", 64'(DONE_LATENCY), 64'(steps - 1));
    end
    repeat (3) begin
      step();
      check_value("done", 64'(1), 64'(done));
    end
    start = 1'b0;
    step();
    check_value("done", 64'(0), 64'(done));
  endtask

  task automatic read_results();
    for (int d = 0; d < `DIAG_COUNT; d++) begin
      read_addr = addr_t'(d);
      step();
      check_value($sformatf("read_data[%0d]", d), 64'(diag_word(d)), 64'(read_data));
    end
  endtask

  task automatic report_test(int num, string name);
    if (errors == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
    end
  endtask

  //////////////////////////////
  // test sequence

  initial begin
    void'($urandom(32'he877));
    reset     = 1'b1;
    load      = 1'b0;
    load_a    = 1'b0;
    load_b    = 1'b0;
    start     = 1'b0;
    load_addr = '0;
    read_addr = '0;
    load_data = '0;
    repeat (RESET_CYCLES) step();
    reset = 1'b0;

    // idle after reset
    errs_before = errors;
    repeat (2) step();
    check_value("done", 64'(0), 64'(done));
    report_test(1, "idle after reset");

    // identity times B gives B back
    errs_before = errors;
    fill_random(1, 256);
    for (int i = 0; i < `ARRAY_N; i++) begin
      ma[i][i] = elem_t'(1);
      for (int j = 0; j < `ARRAY_N; j++) begin
        exp_c[i][j] = mb[i][j];
      end
    end
    load_operands();
    run_once();
    read_results();
    report_test(2, "identity");

    // small random operands, no clamping possible
    errs_before = errors;
    fill_random(128, 128);
    compute_product();
    load_operands();
    run_once();
    read_results();
    report_test(3, "random product");

    // rows 0 and 2 of A force sums past 0xffff
    errs_before = errors;
    for (int i = 0; i < `ARRAY_N; i++) begin
      for (int j = 0; j < `ARRAY_N; j++) begin
        case (i)
          0: ma[i][j] = elem_t'(16'h0100);
          2: ma[i][j] = elem_t'(16'hffff);
          default: ma[i][j] = elem_t'($urandom_range(15));
        endcase
        mb[i][j] = (j < 2) ? elem_t'(16'h0100) : elem_t'($urandom_range(7));
      end
    end
    compute_product();
    load_operands();
    run_once();
    read_results();
    report_test(4, "saturation");

    // back to back runs, second must not carry old sums
    errs_before = errors;
    fill_random(128, 128);
    compute_product();
    load_operands();
    run_once();
    read_results();
    fill_random(128, 128);
    compute_product();
    load_operands();
    run_once();
    read_results();
    report_test(5, "timing and rerun");

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- verilog/matmul_top.sv
`timescale 1ns/100ps
`include "matmul_macros.svh"

module matmul_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              load_a,
  input  logic              load_b,
  input  logic              start,
  input  matmul_pkg::addr_t load_addr,
  input  matmul_pkg::addr_t read_addr,
  input  matmul_pkg::word_t load_data,
  output logic              done,
  output matmul_pkg::word_t read_data
);
  import matmul_pkg::*;

  // sequencer controls
  addr_t rd_addr;
  logic  feed;
  logic  wr_en;
  addr_t wr_diag;

  // skewed operand streams into the array
  word_t a_lanes;
  word_t b_lanes;

  // packed anti-diagonal out of the array
  word_t result_word;

  //////////////////////////////
  // control

  matmul_sequencer seq_i (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .rd_addr (rd_addr),
    .feed    (feed),
    .wr_en   (wr_en),
    .done    (done),
    .wr_diag (wr_diag)
  );

  //////////////////////////////
  // operand memories

  // A memory, word k = column k of A
  operand_feeder feed_a_i (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .load_we   (load_a),
    .feed      (feed),
    .load_addr (load_addr),
    .rd_addr   (rd_addr),
    .load_data (load_data),
    .lanes     (a_lanes)
  );

  // B memory, word k = row k of B
  operand_feeder feed_b_i (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .load_we   (load_b),
    .feed      (feed),
    .load_addr (load_addr),
    .rd_addr   (rd_addr),
    .load_data (load_data),
    .lanes     (b_lanes)
  );

  //////////////////////////////
  // compute and results

  systolic_array array_i (
    .clk         (clk),
    .reset       (reset),
    .feed        (feed),
    .wr_en       (wr_en),
    .a_lanes     (a_lanes),
    .b_lanes     (b_lanes),
    .wr_diag     (wr_diag),
    .result_word (result_word)
  );

  // write side owned by the array, read side by the host
  result_bank result_i (
    .clk       (clk),
    .wr_en     (wr_en),
    .wr_addr   (wr_diag),
    .read_addr (read_addr),
    .wr_data   (result_word),
    .read_data (read_data)
  );

endmodule

//--- verilog/result_bank.sv
`timescale 1ns/100ps
`include "matmul_macros.svh"

module result_bank (
  input  logic              clk,
  input  logic              wr_en,
  input  matmul_pkg::addr_t wr_addr,
  input  matmul_pkg::addr_t read_addr,
  input  matmul_pkg::word_t wr_data,
  output matmul_pkg::word_t read_data
);
  import matmul_pkg::*;

  word_t mem [`MEM_DEPTH];

  //////////////////////////////
  // write port

  // one diagonal per write-out cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////
  // host read port

  // one cycle of latency
  always_ff @(posedge clk) begin
    read_data <= mem[read_addr];
  end

endmodule

//--- verilog/systolic_array.sv
`timescale 1ns/100ps
`include "matmul_macros.svh"

module systolic_array (
  input  logic              clk,
  input  logic              reset,
  input  logic              feed,
  input  logic              wr_en,
  input  matmul_pkg::word_t a_lanes,
  input  matmul_pkg::word_t b_lanes,
  input  matmul_pkg::addr_t wr_diag,
  output matmul_pkg::word_t result_word
);
  import matmul_pkg::*;

  // operand registers passed to the right and downward neighbours
  elem_t a_reg [`ARRAY_N][`ARRAY_N-1];
  elem_t b_reg [`ARRAY_N-1][`ARRAY_N];

  // running sums
  acc_t  acc [`ARRAY_N][`ARRAY_N];

  // sums clamped to element width
  elem_t sat [`ARRAY_N][`ARRAY_N];

  //////////////////////////////
  // MAC grid

  // cell (r, c) sees A[r][k] and B[k][c] on the same cycle
  // since lane r of A and lane c of B arrive r+c cycles late
  for (genvar r = 0; r < `ARRAY_N; r++) begin : g_row
    for (genvar c = 0; c < `ARRAY_N; c++) begin : g_col
      elem_t a_in;
      elem_t b_in;

      // left column takes A straight from the feeder
      if (c == 0) begin : g_a_edge
        assign a_in = a_lanes[r*`ELEM_W +: `ELEM_W];
      end else begin : g_a_inner
        assign a_in = a_reg[r][c-1];
      end

      // top row takes B straight from the feeder
      if (r == 0) begin : g_b_edge
        assign b_in = b_lanes[c*`ELEM_W +: `ELEM_W];
      end else begin : g_b_inner
        assign b_in = b_reg[r-1][c];
      end

      // operand pipeline, flushed outside the window
      // last column has no right neighbour
      if (c < `ARRAY_N-1) begin : g_a_pass
        always_ff @(posedge clk) begin
          if (reset || !feed) begin
            a_reg[r][c] <= '0;
          end else begin
            a_reg[r][c] <= a_in;
          end
        end
      end

      // last row has no downward neighbour
      if (r < `ARRAY_N-1) begin : g_b_pass
        always_ff @(posedge clk) begin
          if (reset || !feed) begin
            b_reg[r][c] <= '0;
          end else begin
            b_reg[r][c] <= b_in;
          end
        end
      end

      // accumulate in the window
      // hold during write-out, clear otherwise
      always_ff @(posedge clk) begin
        if (reset) begin
          acc[r][c] <= '0;
        end else if (feed) begin
          acc[r][c] <= acc[r][c] + acc_t'(a_in) * acc_t'(b_in);
        end else if (!wr_en) begin
          acc[r][c] <= '0;
        end
      end

      // anything above 0xffff pins to all ones
      assign sat[r][c] = (|acc[r][c][2*`ELEM_W-1:`ELEM_W]) ?
                         '1 : acc[r][c][`ELEM_W-1:0];
    end
  end

  //////////////////////////////
  // diagonal packing

  // lane r of word d carries C[r][d-r]
  // lanes with d-r outside 0..3 stay zero
  always_comb begin
    result_word = '0;
    for (int r = 0; r < `ARRAY_N; r++) begin
      for (int c = 0; c < `ARRAY_N; c++) begin
        if (int'(wr_diag) == r + c) begin
          result_word[r*`ELEM_W +: `ELEM_W] = sat[r][c];
        end
      end
    end
  end

endmodule

//--- verilog/matmul_sequencer.sv
`timescale 1ns/100ps
`include "matmul_macros.svh"

module matmul_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  output matmul_pkg::addr_t rd_addr,
  output logic              feed,
  output logic              wr_en,
  output logic              done,
  output matmul_pkg::addr_t wr_diag
);
  import matmul_pkg::*;

  seq_state_t state;
  count_t     cnt;

  // count offset of the current diagonal inside write-out
  count_t     diag_cnt;

  //////////////////////////////
  // state and counter

  // first edge with start high moves idle -> compute at count 0
  // count then advances once per cycle until done
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      state <= idle;
      cnt   <= '0;
    end else begin
      case (state)
        idle: begin
          state <= compute;
        end
        compute: begin
          cnt <= cnt + count_t'(1);
          // last accumulate cycle, next count starts write-out
          if (cnt == count_t'(`FEED_CYCLES - 1)) begin
            state <= write_out;
          end
        end
        write_out: begin
          if (cnt == count_t'(`DONE_COUNT)) begin
            state <= finished;
          end else begin
            cnt <= cnt + count_t'(1);
          end
        end
        finished: begin
          // hold until start drops
          state <= finished;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  //////////////////////////////
  // decoded controls

  // operand reads at counts 0..3, otherwise park on the top word
  assign rd_addr = (state == compute && cnt < count_t'(`ARRAY_N)) ?
                   addr_t'(cnt) : addr_t'(`MEM_DEPTH - 1);

  // accumulate window, counts 1..11
  assign feed = (state == compute) && (cnt != '0);

  // one diagonal per cycle from count 12
  assign diag_cnt = cnt - count_t'(`FEED_CYCLES);
  assign wr_en    = (state == write_out) && (cnt < count_t'(`FEED_CYCLES + `DIAG_COUNT));
  assign wr_diag  = wr_en ? addr_t'(diag_cnt) : '0;

  // high for as long as start is held after write-out
  assign done = (state == finished);

endmodule

//--- verilog/operand_feeder.sv
`timescale 1ns/100ps
`include "matmul_macros.svh"

module operand_feeder (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              load_we,
  input  logic              feed,
  input  matmul_pkg::addr_t load_addr,
  input  matmul_pkg::addr_t rd_addr,
  input  matmul_pkg::word_t load_data,
  output matmul_pkg::word_t lanes
);
  import matmul_pkg::*;

  word_t mem [`MEM_DEPTH];
  word_t mem_q;
  addr_t mem_addr;

  // read data came from an operand word, not the idle address
  logic  q_valid;

  // per-lane output after skew
  elem_t lane_out [`ARRAY_N];

  //////////////////////////////
  // operand memory

  // host owns the address while loading
  assign mem_addr = load ? load_addr : rd_addr;

  always_ff @(posedge clk) begin
    if (load && load_we) begin
      mem[mem_addr] <= load_data;
    end
    mem_q <= mem[mem_addr];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= !load && (rd_addr != addr_t'(`MEM_DEPTH - 1));
    end
  end

  //////////////////////////////
  // lane skew

  // lane i goes through i stages so the array sees a wavefront
  for (genvar i = 0; i < `ARRAY_N; i++) begin : g_lane
    elem_t lane_in;

    // zero outside the read window keeps the idle word out of the sums
    assign lane_in = q_valid ? mem_q[i*`ELEM_W +: `ELEM_W] : '0;

    if (i == 0) begin : g_direct
      assign lane_out[i] = lane_in;
    end else begin : g_skew
      elem_t stage [i];

      always_ff @(posedge clk) begin
        if (reset || !feed) begin
          for (int s = 0; s < i; s++) begin
            stage[s] <= '0;
          end
        end else begin
          stage[0] <= lane_in;
          for (int s = 1; s < i; s++) begin
            stage[s] <= stage[s-1];
          end
        end
      end

      assign lane_out[i] = stage[i-1];
    end
  end

  // repack lanes into one word
  always_comb begin
    for (int i = 0; i < `ARRAY_N; i++) begin
      lanes[i*`ELEM_W +: `ELEM_W] = lane_out[i];
    end
  end

endmodule

//--- verilog/matmul_pkg.sv
`include "matmul_macros.svh"

package matmul_pkg;

  // one matrix element
  typedef logic [`ELEM_W-1:0] elem_t;

  // accumulator, full product width
  typedef logic [2*`ELEM_W-1:0] acc_t;

  // memory address
  typedef logic [`ADDR_W-1:0] addr_t;

  // memory word, lane k in bits 16k +: 16
  typedef logic [`ARRAY_N*`ELEM_W-1:0] word_t;

  // sequencer cycle counter
  typedef logic [7:0] count_t;

  // sequencer states
  typedef enum logic [1:0] {
    idle,
    compute,
    write_out,
    finished
  } seq_state_t;

endpackage

//--- verilog/matmul_macros.svh
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// element and address sizes
`define ELEM_W 16
`define ADDR_W 7

// words per operand or result memory
`define MEM_DEPTH 128

// matrix dimension, also lanes per memory word
`define ARRAY_N 4

// one result word per anti-diagonal
`define DIAG_COUNT 7

// sequencer counter milestones
`define FEED_CYCLES 12
`define DONE_COUNT 19

`endif
